// File: source/pdp8Pkg.sv
// shared types and constants for the 12-bit processor
// bit fields use [11:0] numbering, so bit 11 is the PDP-8 bit 0
// no IOT, interrupt or extended memory encodings are defined
package pdp8Pkg;

    typedef logic [11:0] pdp8Word;      // AC, PC, MA, MB and core data

    // memory reference and operate opcodes, instruction bits 11:9
    typedef enum logic [2:0] {
        opAnd = 3'd0,
        opTad = 3'd1,
        opIsz = 3'd2,
        opDca = 3'd3,
        opJms = 3'd4,
        opJmp = 3'd5,
        opIot = 3'd6,                   // runs as a plain fetch
        opOpr = 3'd7
    } opcodeT;

    typedef enum logic [2:0] {
        msHalt,                         // waiting on the console
        msFetch,
        msDefer,                        // reading the pointer word
        msExec,
        msDeposit,                      // console memory cycles
        msExamine
    } majorStateT;

    // one clock per time state, tsIdle only while halted
    typedef enum logic [2:0] {tsIdle, ts1, ts2, ts3, ts4} timeStateT;

    typedef enum logic [1:0] {
        cmdLoadAddr = 2'd0,
        cmdDeposit  = 2'd1,
        cmdExamine  = 2'd2,
        cmdStart    = 2'd3
    } consoleCmdT;

    // instruction word fields
    localparam int INDIRECT_BIT = 8;    // defer through the addressed word
    localparam int CURPAGE_BIT  = 7;    // 0 selects page zero
    localparam int OFFSET_BITS  = 7;    // word within the page

    // MA[11:3] of locations 0010 to 0017
    localparam logic [8:0] AUTO_INDEX_PAGE = 9'o001;

endpackage

// File: source/coreMemory.sv
`timescale 1ns/1ns
// single-port core with synchronous read and write
// only the low CORE_ADDR_BITS of the address are decoded, so keep it at 12 or less
// a read in the same clock as a write returns the old word
module coreMemory import pdp8Pkg::*; #(
    parameter int CORE_ADDR_BITS = 12
) (
    input  logic    CLOCK,
    input  pdp8Word i_addr,
    input  logic    i_write,
    input  pdp8Word i_wData,
    output pdp8Word o_rData
);

    localparam int DEPTH = 1 << CORE_ADDR_BITS;

    pdp8Word                   coreArray [DEPTH];   // contents survive reset
    logic [CORE_ADDR_BITS-1:0] addrLow;

    // smaller cores wrap onto the low addresses
    assign addrLow = i_addr[CORE_ADDR_BITS-1:0];

    always_ff @(posedge CLOCK) begin
        if (i_write)
            coreArray[addrLow] <= i_wData;      // restore or modified word
        o_rData <= coreArray[addrLow];          // read every clock
    end

endmodule

// File: source/operateUnit.sv
`timescale 1ns/1ns
// group 1 and group 2 operate logic, purely combinational
// does not check the opcode, bit 8 alone picks the group
// OSR and the group 3 (EAE) bits are ignored
module operateUnit import pdp8Pkg::*; (
    input  pdp8Word i_instr,
    input  pdp8Word i_ac,
    input  logic    i_link,
    output pdp8Word o_ac,
    output logic    o_link,
    output logic    o_skip,
    output logic    o_halt
);

    logic        group2;
    logic [12:0] g1Raw;         // {link, ac} after clear, complement, increment
    logic [12:0] g1Rot;         // after the rotate field
    logic        skipAny;
    pdp8Word     g2Ac;

    assign group2 = i_instr[8];

    ////////////////////////////////////////
    // group 1

    // CLA/CLL first, then CMA/CML, IAC last with carry into link
    assign g1Raw = {(i_instr[6] ? 1'b0 : i_link) ^ i_instr[4],
                    (i_instr[7] ? 12'o0000 : i_ac) ^ {12{i_instr[5]}}}
                   + {12'd0, i_instr[0]};

    // rotates work on the 13-bit link:ac pair
    always_comb begin
        case (i_instr[3:1])
            3'b010:  g1Rot = {g1Raw[11:0], g1Raw[12]};         // RAL
            3'b011:  g1Rot = {g1Raw[10:0], g1Raw[12:11]};      // RTL
            3'b100:  g1Rot = {g1Raw[0], g1Raw[12:1]};          // RAR
            3'b101:  g1Rot = {g1Raw[1:0], g1Raw[12:2]};        // RTR
            default: g1Rot = g1Raw;                            // no rotate
        endcase
    end

    ////////////////////////////////////////
    // group 2

    // OR of the selected conditions, tested on AC before CLA
    assign skipAny = (i_instr[6] & i_ac[11])           // SMA
                   | (i_instr[5] & (i_ac == 12'o0000)) // SZA
                   | (i_instr[4] & i_link);            // SNL

    assign g2Ac = i_instr[7] ? 12'o0000 : i_ac;        // CLA after the test

    assign o_ac   = group2 ? g2Ac : g1Rot[11:0];
    assign o_link = group2 ? i_link : g1Rot[12];
    assign o_skip = group2 & (skipAny ^ i_instr[3]);   // bit 3 reverses the sense
    assign o_halt = group2 & i_instr[1];               // HLT

endmodule

// File: source/memrefUnit.sv
`timescale 1ns/1ns
// memory reference arithmetic, purely combinational
// effective address is only meaningful while MB holds the instruction (fetch)
// the page comes from MA, which still points at the instruction then
module memrefUnit import pdp8Pkg::*; (
    input  pdp8Word    i_mb,
    input  pdp8Word    i_ma,
    input  pdp8Word    i_ac,
    input  logic       i_link,
    input  pdp8Word    i_pc,
    input  majorStateT i_state,
    input  opcodeT     i_opcode,
    input  logic       i_defer,
    output pdp8Word    o_effAddr,
    output pdp8Word    o_tadAc,
    output logic       o_tadLink,
    output pdp8Word    o_andAc,
    output pdp8Word    o_writeBack,
    output logic       o_iszZero
);

    logic [11-OFFSET_BITS:0] pageBits;
    pdp8Word                 mbPlusOne;
    logic                    autoIndex;

    // page zero or current page
    assign pageBits  = i_mb[CURPAGE_BIT] ? i_ma[11:OFFSET_BITS] : '0;
    assign o_effAddr = {pageBits, i_mb[OFFSET_BITS-1:0]};

    // 13-bit add, carry out toggles the link
    assign {o_tadLink, o_tadAc} = {i_link, i_ac} + {1'b0, i_mb};
    assign o_andAc = i_ac & i_mb;

    assign mbPlusOne = i_mb + 12'd1;
    assign o_iszZero = (mbPlusOne == 12'o0000);    // ISZ wrapped, skip next

    // pointer in 0010..0017 read during a defer cycle
    assign autoIndex = i_defer && (i_state == msDefer)
                    && (i_ma[11:3] == AUTO_INDEX_PAGE);

    // word restored to core in ts3
    always_comb begin
        o_writeBack = i_mb;                         // plain restore
        if (autoIndex)
            o_writeBack = mbPlusOne;
        else if (i_state == msExec) begin
            case (i_opcode)
                opIsz:   o_writeBack = mbPlusOne;
                opDca:   o_writeBack = i_ac;
                opJms:   o_writeBack = i_pc;        // return address
                default: o_writeBack = i_mb;
            endcase
        end
    end

endmodule

// File: source/cycleSequencer.sv
`timescale 1ns/1ns
// major-state and time-state sequencer with the programmer-visible registers
// AC, link, PC, MA, MB and IR have no reset, load an address before depositing
// console commands are only taken while halted, under a four-phase req/ack
module cycleSequencer import pdp8Pkg::*; (
    input  logic       CLOCK,
    input  logic       RESET,
    input  logic       i_cmdReq,
    input  consoleCmdT i_cmdOp,
    input  pdp8Word    i_cmdData,
    input  pdp8Word    i_memRData,
    input  pdp8Word    i_opAc,
    input  logic       i_opLink,
    input  logic       i_opSkip,
    input  logic       i_opHalt,
    input  pdp8Word    i_effAddr,
    input  pdp8Word    i_tadAc,
    input  logic       i_tadLink,
    input  pdp8Word    i_andAc,
    input  pdp8Word    i_writeBack,
    input  logic       i_iszZero,
    output logic       o_cmdAck,
    output logic       o_run,
    output pdp8Word    o_ac,
    output logic       o_link,
    output pdp8Word    o_pc,
    output pdp8Word    o_mb,
    output pdp8Word    o_ma,
    output pdp8Word    o_ir,
    output majorStateT o_state,
    output pdp8Word    o_memAddr,
    output logic       o_memWrite,
    output pdp8Word    o_memWData
);

    majorStateT majorState, nextState, nextSel;
    timeStateT  timeState;
    logic       cmdActive;              // command running, ack when idle again
    logic       cmdAck;
    logic       cmdAccept;
    pdp8Word    ac, pc, ma, mb, ir;
    logic       link;
    opcodeT     opcode;
    pdp8Word    acNext, pcNext, maNext, target;
    logic       linkNext;

    assign opcode    = opcodeT'(ir[11:9]);
    assign cmdAccept = (majorState == msHalt) && (timeState == tsIdle)
                    && !cmdActive && !cmdAck && i_cmdReq;

    // major state after this cycle, latched in ts3
    always_comb begin
        case (majorState)
            msFetch: begin
                if (opcode == opOpr)
                    nextSel = i_opHalt ? msHalt : msFetch;
                else if (opcode == opIot)
                    nextSel = msFetch;
                else if (ir[INDIRECT_BIT])
                    nextSel = msDefer;
                else
                    nextSel = (opcode == opJmp) ? msFetch : msExec;
            end
            msDefer: nextSel = (opcode == opJmp) ? msFetch : msExec;
            msExec:  nextSel = msFetch;
            default: nextSel = msHalt;          // console cycles stop here
        endcase
    end

    // ts4 register updates, merged by opcode from both units
    always_comb begin
        acNext   = ac;
        linkNext = link;
        pcNext   = pc;
        target   = ma;                          // address of a defer or exec cycle
        case (majorState)
            msFetch: begin
                pcNext = pc + 12'd1;
                target = i_effAddr;
                if (opcode == opOpr) begin
                    acNext   = i_opAc;
                    linkNext = i_opLink;
                    if (i_opSkip)
                        pcNext = pc + 12'd2;
                end else if (opcode == opJmp && !ir[INDIRECT_BIT]) begin
                    pcNext = i_effAddr;         // direct JMP ends in fetch
                end
            end
            msDefer: begin
                target = i_writeBack;           // pointer, already bumped if auto-index
                if (opcode == opJmp)
                    pcNext = i_writeBack;
            end
            msExec: begin
                case (opcode)
                    opAnd: acNext = i_andAc;
                    opTad: begin
                        acNext   = i_tadAc;
                        linkNext = i_tadLink;
                    end
                    opIsz: begin
                        if (i_iszZero)
                            pcNext = pc + 12'd1;
                    end
                    opDca: acNext = 12'o0000;
                    opJms: pcNext = ma + 12'd1; // continue after the stored return
                    default: acNext = ac;
                endcase
            end
            default: pcNext = pc;
        endcase
    end

    assign maNext = (nextState == msDefer || nextState == msExec) ? target : pcNext;

    ////////////////////////////////////////
    // control state

    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            majorState <= msHalt;
            nextState  <= msHalt;
            timeState  <= tsIdle;
            cmdActive  <= 1'b0;
            cmdAck     <= 1'b0;
        end else begin
            if (cmdAck && !i_cmdReq)
                cmdAck <= 1'b0;                 // host has released the request
            case (timeState)
                tsIdle: begin
                    if (cmdActive) begin
                        cmdAck    <= 1'b1;
                        cmdActive <= 1'b0;
                    end else if (cmdAccept) begin
                        cmdActive <= 1'b1;
                        if (i_cmdOp != cmdLoadAddr)
                            timeState <= ts1;   // load address needs no memory cycle
                        case (i_cmdOp)
                            cmdDeposit: majorState <= msDeposit;
                            cmdExamine: majorState <= msExamine;
                            cmdStart:   majorState <= msFetch;
                            default:    majorState <= msHalt;
                        endcase
                    end
                end
                ts1: timeState <= ts2;          // MA on the memory address
                ts2: timeState <= ts3;          // read data into MB
                ts3: begin
                    nextState <= nextSel;
                    timeState <= ts4;
                end
                ts4: begin
                    majorState <= nextState;
                    timeState  <= (nextState == msHalt) ? tsIdle : ts1;
                end
                default: timeState <= tsIdle;
            endcase
        end
    end

    ////////////////////////////////////////
    // datapath registers

    always_ff @(posedge CLOCK) begin
        if (cmdAccept) begin
            case (i_cmdOp)
                cmdLoadAddr: begin
                    pc <= i_cmdData;
                    ma <= i_cmdData;
                end
                cmdDeposit, cmdExamine: begin
                    ma <= pc;
                    pc <= pc + 12'd1;           // console steps through core
                end
                default: begin                  // start runs from PC with AC, L clear
                    ac   <= 12'o0000;
                    link <= 1'b0;
                    ma   <= pc;
                end
            endcase
        end
        if (timeState == ts2) begin
            mb <= (majorState == msDeposit) ? i_cmdData : i_memRData;
            if (majorState == msFetch)
                ir <= i_memRData;               // opcode and defer bit kept for the instruction
        end
        if (timeState == ts4) begin
            ac   <= acNext;
            link <= linkNext;
            pc   <= pcNext;
            ma   <= maNext;
        end
    end

    assign o_memAddr  = ma;
    assign o_memWrite = (timeState == ts3);     // every cycle restores its word
    assign o_memWData = i_writeBack;

    assign o_cmdAck = cmdAck;
    assign o_run    = (majorState == msFetch) || (majorState == msDefer)
                   || (majorState == msExec);
    assign o_ac     = ac;
    assign o_link   = link;
    assign o_pc     = pc;
    assign o_mb     = mb;
    assign o_ma     = ma;
    assign o_ir     = ir;
    assign o_state  = majorState;

endmodule

// File: source/pdp8Core.sv
`timescale 1ns/1ns
// 12-bit processor top, sequencer plus operate and memory reference units
// CORE_ADDR_BITS below 12 gives a smaller core that wraps on the low MA bits
module pdp8Core import pdp8Pkg::*; #(
    parameter int CORE_ADDR_BITS = 12
) (
    input  logic       CLOCK,
    input  logic       RESET,
    input  logic       i_cmdReq,
    input  consoleCmdT i_cmdOp,
    input  pdp8Word    i_cmdData,
    output logic       o_cmdAck,
    output logic       o_run,
    output pdp8Word    o_ac,
    output logic       o_link,
    output pdp8Word    o_pc,
    output pdp8Word    o_mb
);

    pdp8Word    ma, ir, memAddr, memWData, memRData;
    logic       memWrite;
    majorStateT state;
    pdp8Word    opAc, effAddr, tadAc, andAc, writeBack;
    logic       opLink, opSkip, opHalt, tadLink, iszZero;

    ////////////////////////////////////////
    // sequencer and registers

    cycleSequencer cycleSequencer_inst (
        .CLOCK(CLOCK), .RESET(RESET),
        .i_cmdReq(i_cmdReq), .i_cmdOp(i_cmdOp), .i_cmdData(i_cmdData),
        .i_memRData(memRData),
        .i_opAc(opAc), .i_opLink(opLink), .i_opSkip(opSkip), .i_opHalt(opHalt),
        .i_effAddr(effAddr), .i_tadAc(tadAc), .i_tadLink(tadLink), .i_andAc(andAc),
        .i_writeBack(writeBack), .i_iszZero(iszZero),
        .o_cmdAck(o_cmdAck), .o_run(o_run), .o_ac(o_ac), .o_link(o_link),
        .o_pc(o_pc), .o_mb(o_mb), .o_ma(ma), .o_ir(ir), .o_state(state),
        .o_memAddr(memAddr), .o_memWrite(memWrite), .o_memWData(memWData)
    );

    // both units see the same registers, the sequencer picks by opcode
    operateUnit operateUnit_inst (
        .i_instr(o_mb), .i_ac(o_ac), .i_link(o_link),
        .o_ac(opAc), .o_link(opLink), .o_skip(opSkip), .o_halt(opHalt)
    );

    memrefUnit memrefUnit_inst (
        .i_mb(o_mb), .i_ma(ma), .i_ac(o_ac), .i_link(o_link), .i_pc(o_pc),
        .i_state(state), .i_opcode(opcodeT'(ir[11:9])), .i_defer(ir[INDIRECT_BIT]),
        .o_effAddr(effAddr), .o_tadAc(tadAc), .o_tadLink(tadLink), .o_andAc(andAc),
        .o_writeBack(writeBack), .o_iszZero(iszZero)
    );

    coreMemory #(.CORE_ADDR_BITS(CORE_ADDR_BITS)) coreMemory_inst (
        .CLOCK(CLOCK), .i_addr(memAddr), .i_write(memWrite),
        .i_wData(memWData), .o_rData(memRData)
    );

endmodule

// File: sim/tbClock.sv
`timescale 1ns/1ns
// clock and reset source for the testbench, 10 ns period
// RESET is high for the first 4 rising edges and drops on a falling edge
module tbClock (
    output logic CLOCK,
    output logic RESET
);

    initial begin
        CLOCK = 1'b0;
        forever #5 CLOCK = ~CLOCK;
    end

    initial begin
        RESET = 1'b1;
        repeat (4) @(posedge CLOCK);
        @(negedge CLOCK);               // release away from the active edge
        RESET = 1'b0;
    end

endmodule

// File: sim/pdp8CoreSva.sv
`timescale 1ns/1ns
// console handshake properties bound into pdp8Core
// all properties are off while RESET is high
module pdp8CoreSva (
    input logic CLOCK,
    input logic RESET,
    input logic i_cmdReq,
    input logic o_cmdAck,
    input logic o_run
);

    int failCount = 0;                  // failed properties so far

    // ack is only ever an answer to a pending request
    ackNeedsReq: assert property (@(posedge CLOCK) disable iff (RESET)
        $rose(o_cmdAck) |-> $past(i_cmdReq))
        else begin
            $error("o_cmdAck rose with no request pending");
            failCount++;
        end

    // ack holds under back-pressure while the host keeps req high
    ackHeld: assert property (@(posedge CLOCK) disable iff (RESET)
        (o_cmdAck && i_cmdReq) |=> o_cmdAck)
        else begin
            $error("o_cmdAck dropped before i_cmdReq fell");
            failCount++;
        end

    haltedOnAck: assert property (@(posedge CLOCK) disable iff (RESET)
        o_cmdAck |-> !o_run)
        else begin
            $error("o_run high while o_cmdAck is high");
            failCount++;
        end

endmodule

bind pdp8Core pdp8CoreSva pdp8CoreSva_inst (
    .CLOCK(CLOCK), .RESET(RESET), .i_cmdReq(i_cmdReq),
    .o_cmdAck(o_cmdAck), .o_run(o_run)
);

// File: sim/pdp8CoreTb.sv
`timescale 1ns/1ns
// directed tests through the console port only
// core is never cleared so each test deposits every word it later reads
// inputs change and outputs are read on the falling edge
module pdp8CoreTb import pdp8Pkg::*; ();

    localparam int ACK_LIMIT  = 1000;   // longest program needs about 150 clocks
    localparam int DROP_LIMIT = 10;     // ack drops one clock after req

    logic       CLOCK, RESET;
    logic       cmdReq;
    consoleCmdT cmdOp;
    pdp8Word    cmdData;
    logic       cmdAck, run, link;
    pdp8Word    ac, pc, mb;

    integer     seed;
    int         checkCount, errorCount, timeoutCount;
    pdp8Word    blockWords [$];         // words for the next depositBlock

    tbClock tbClock_inst (.CLOCK(CLOCK), .RESET(RESET));

    pdp8Core #(.CORE_ADDR_BITS(12)) pdp8Core_inst (
        .CLOCK(CLOCK), .RESET(RESET),
        .i_cmdReq(cmdReq), .i_cmdOp(cmdOp), .i_cmdData(cmdData),
        .o_cmdAck(cmdAck), .o_run(run), .o_ac(ac), .o_link(link),
        .o_pc(pc), .o_mb(mb)
    );

    task automatic checkValue(input string testName, input pdp8Word expected,
                              input pdp8Word actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("error %s: expected %o, actual %o", testName, expected, actual);
        end
    endtask

    ////////////////////////////////////////
    // console handshake

    task automatic waitAckHigh(input string what);
        int waitCount;
        waitCount = 0;
        while (!cmdAck && waitCount < ACK_LIMIT) begin
            @(negedge CLOCK);
            waitCount++;
        end
        if (!cmdAck) begin
            timeoutCount++;
            $display("no acknowledge for %s within %0d clocks", what, ACK_LIMIT);
        end
    endtask

    task automatic waitAckLow();
        int waitCount;
        waitCount = 0;
        while (cmdAck && waitCount < DROP_LIMIT) begin
            @(negedge CLOCK);
            waitCount++;
        end
        if (cmdAck) begin
            timeoutCount++;
            $display("acknowledge stayed high after the request was dropped");
        end
    endtask

    // full four-phase command that returns with ack low again
    task automatic consoleCmd(input consoleCmdT op, input pdp8Word data);
        @(negedge CLOCK);
        cmdOp   = op;
        cmdData = data;
        cmdReq  = 1'b1;
        waitAckHigh(op.name());
        cmdReq  = 1'b0;
        waitAckLow();
    endtask

    task automatic depositBlock(input pdp8Word addr);
        consoleCmd(cmdLoadAddr, addr);
        foreach (blockWords[i])
            consoleCmd(cmdDeposit, blockWords[i]);     // PC steps on by itself
    endtask

    task automatic examineAt(input pdp8Word addr, output pdp8Word word);
        consoleCmd(cmdLoadAddr, addr);
        consoleCmd(cmdExamine, 12'o0000);
        word = mb;
    endtask

    task automatic runFrom(input pdp8Word addr);
        consoleCmd(cmdLoadAddr, addr);
        consoleCmd(cmdStart, 12'o0000);                // ack comes at HLT
    endtask

    ////////////////////////////////////////
    // reference models

    // group 1 applies CLA CLL then CMA CML then IAC into the link and the rotate last
    function automatic logic [12:0] group1Model(input pdp8Word instr, input pdp8Word acIn,
                                                input logic linkIn);
        logic [12:0] la;
        int          shifts;
        la = {linkIn, acIn};
        if (instr[7])
            la[11:0] = 12'o0000;
        if (instr[6])
            la[12] = 1'b0;
        if (instr[5])
            la[11:0] = ~la[11:0];
        if (instr[4])
            la[12] = ~la[12];
        if (instr[0])
            la = la + 13'd1;                            // carry out flips L
        shifts = instr[1] ? 2 : 1;                      // RTL/RTR twice
        for (int i = 0; i < shifts; i++) begin
            if (instr[2])
                la = {la[11:0], la[12]};
            if (instr[3])
                la = {la[0], la[12:1]};
        end
        return la;
    endfunction

    // OR of SMA SZA SNL where bit 3 turns it into SPA SNA SZL
    function automatic logic skipModel(input pdp8Word instr, input pdp8Word acIn,
                                       input logic linkIn);
        logic cond;
        cond = (instr[6] && acIn[11]) || (instr[5] && acIn == 12'o0000)
            || (instr[4] && linkIn);
        return cond ^ instr[3];
    endfunction

    // program is CLA CLL, TAD value, CML or NOP, instruction, ISZ marker and HLT
    // operand and marker sit at base+020
    task automatic runOperate(input pdp8Word base, input pdp8Word value, input logic linkIn,
                              input pdp8Word instr);
        blockWords = {12'o7300, 12'o1220, (linkIn ? 12'o7020 : 12'o7000), instr,
                      12'o2221, 12'o7402};
        depositBlock(base);
        blockWords = {value, 12'o0000};
        depositBlock(base + 12'o0020);
        runFrom(base);
    endtask

    ////////////////////////////////////////
    // directed tests

    task automatic handshakeTest();
        pdp8Word target;
        int      lowCount;
        checkValue("reset ack", 12'o0000, pdp8Word'(cmdAck));
        checkValue("reset run", 12'o0000, pdp8Word'(run));
        target = pdp8Word'($random(seed));
        @(negedge CLOCK);
        cmdOp   = cmdLoadAddr;
        cmdData = target;
        cmdReq  = 1'b1;
        waitAckHigh("held load address");
        lowCount = 0;
        repeat (20) begin                               // host keeps req high
            @(negedge CLOCK);
            if (!cmdAck)
                lowCount++;
        end
        checkValue("held request ack low clocks", 12'o0000, pdp8Word'(lowCount));
        checkValue("held request pc", target, pc);
        cmdReq = 1'b0;
        waitAckLow();
        checkValue("released request ack", 12'o0000, pdp8Word'(cmdAck));
    endtask

    task automatic depositExamineTest();
        pdp8Word words [8];
        blockWords = {};
        foreach (words[i]) begin
            words[i] = pdp8Word'($random(seed));
            blockWords.push_back(words[i]);
        end
        depositBlock(12'o0200);
        consoleCmd(cmdLoadAddr, 12'o0200);
        foreach (words[i]) begin
            consoleCmd(cmdExamine, 12'o0000);
            checkValue($sformatf("examine %0d", i), words[i], mb);
        end
        checkValue("examine end pc", 12'o0210, pc);
    endtask

    task automatic arithmeticTest();
        pdp8Word     a, b, m, r;
        logic [12:0] sum;
        a   = pdp8Word'($random(seed));
        b   = pdp8Word'($random(seed));
        m   = pdp8Word'($random(seed));
        sum = {1'b0, a} + {1'b0, b};
        // CLA CLL, TAD A, TAD B, AND M, DCA R, HLT
        blockWords = {12'o7300, 12'o1220, 12'o1221, 12'o0222, 12'o3223, 12'o7402};
        depositBlock(12'o0200);
        blockWords = {a, b, m, 12'o0000};
        depositBlock(12'o0220);
        runFrom(12'o0200);
        checkValue("arithmetic ac", 12'o0000, ac);
        checkValue("arithmetic link", pdp8Word'(sum[12]), pdp8Word'(link));
        examineAt(12'o0223, r);
        checkValue("arithmetic result", sum[11:0] & m, r);
    endtask

    task automatic iszSubroutineTest();
        int      loops;
        pdp8Word word;
        loops = ($random(seed) & 7) + 1;
        // CLA CLL, ISZ 0420, JMP 0401, JMS I 0010, HLT
        blockWords = {12'o7300, 12'o2220, 12'o5201, 12'o4410, 12'o7402};
        depositBlock(12'o0400);
        blockWords = {pdp8Word'(-loops)};
        depositBlock(12'o0420);
        blockWords = {12'o0000, 12'o5640};              // return slot then JMP I 0440
        depositBlock(12'o0440);
        blockWords = {12'o0437};                        // bumped to 0440 before use
        depositBlock(12'o0010);
        runFrom(12'o0400);
        checkValue("isz halt pc", 12'o0405, pc);
        examineAt(12'o0420, word);
        checkValue("isz counter", 12'o0000, word);
        examineAt(12'o0440, word);
        checkValue("jms return address", 12'o0404, word);
        examineAt(12'o0010, word);
        checkValue("auto-index pointer", 12'o0440, word);
    endtask

    task automatic group1Test();
        pdp8Word     ops [4];
        pdp8Word     value;
        logic        linkIn;
        logic [12:0] expected;
        ops = '{12'o7041, 12'o7004, 12'o7012, 12'o7120};    // CMA IAC, RAL, RTR, CLL CML
        for (int pass = 0; pass < 4; pass++) begin
            value  = (pass == 0) ? 12'o0000 : pdp8Word'($random(seed));   // 0 carries on IAC
            linkIn = 1'($random(seed));
            foreach (ops[i]) begin
                runOperate(12'o0600, value, linkIn, ops[i]);
                expected = group1Model(ops[i], value, linkIn);
                checkValue($sformatf("group 1 %o ac", ops[i]), expected[11:0], ac);
                checkValue($sformatf("group 1 %o link", ops[i]), pdp8Word'(expected[12]),
                           pdp8Word'(link));
            end
        end
    endtask

    task automatic group2Test();
        pdp8Word skips [6];
        pdp8Word values [3];
        pdp8Word marker;
        skips  = '{12'o7500, 12'o7440, 12'o7420, 12'o7510, 12'o7450, 12'o7430};
        values = '{12'o0000, 12'o4000, 12'o0123};       // zero, negative, positive
        foreach (skips[i])
            foreach (values[j])
                for (int l = 0; l < 2; l++) begin
                    runOperate(12'o1000, values[j], 1'(l), skips[i]);
                    examineAt(12'o1021, marker);        // 0 means the ISZ was skipped
                    checkValue($sformatf("skip %o ac %o link %0d", skips[i], values[j], l),
                               skipModel(skips[i], values[j], 1'(l)) ? 12'o0000 : 12'o0001,
                               marker);
                    checkValue($sformatf("skip %o keeps ac", skips[i]), values[j], ac);
                end
    endtask

    ////////////////////////////////////////

    initial begin
        int resetWait;
        int assertFails;
        cmdReq       = 1'b0;
        cmdOp        = cmdLoadAddr;
        cmdData      = 12'o0000;
        seed         = 8984;
        checkCount   = 0;
        errorCount   = 0;
        timeoutCount = 0;
        resetWait    = 0;
        while (RESET !== 1'b0 && resetWait < 20) begin
            @(negedge CLOCK);
            resetWait++;
        end
        if (RESET !== 1'b0) begin
            timeoutCount++;
            $display("reset was never released");
        end
        handshakeTest();
        depositExamineTest();
        repeat (3)
            arithmeticTest();
        repeat (2)
            iszSubroutineTest();
        group1Test();
        group2Test();
        assertFails = pdp8Core_inst.pdp8CoreSva_inst.failCount;
        $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 checkCount, errorCount, timeoutCount, assertFails);
        if (errorCount == 0 && timeoutCount == 0 && assertFails == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// File: all.f
source/pdp8Pkg.sv
source/coreMemory.sv
source/operateUnit.sv
source/memrefUnit.sv
source/cycleSequencer.sv
source/pdp8Core.sv
sim/tbClock.sv
sim/pdp8CoreSva.sv
sim/pdp8CoreTb.sv
